// ==== project.f ====
verilog/cache_pkg.sv
verilog/cache_way.sv
verilog/hit_merge.sv
verilog/cache_ctrl.sv
verilog/line_memory.sv
verilog/cache_top.sv
verification/cache_properties.sv
verification/cache_tb.sv

// ==== Bender.yml ====
package:
  name: cache_top

sources:
  - files:
      - verilog/cache_pkg.sv
      - verilog/cache_way.sv
      - verilog/hit_merge.sv
      - verilog/cache_ctrl.sv
      - verilog/line_memory.sv
      - verilog/cache_top.sv
  - target: simulation
    files:
      - verification/cache_properties.sv
      - verification/cache_tb.sv

// ==== verification/cache_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_tb;

  localparam int NUM_SETS = 8;
  localparam int NUM_WAYS = 2;
  localparam int MEM_CREDITS = 2;
  localparam int MEM_LATENCY = 6;
  localparam int NUM_DIRECTED = 16;
  localparam int NUM_RANDOM = 64;
  localparam int NUM_OPS = NUM_DIRECTED + NUM_RANDOM;
  localparam int TIMEOUT_CYCLES = NUM_OPS * (2 * MEM_LATENCY + 12) + 200;

  logic                   clk;
  logic                   reset;
  logic                   req_valid;
  cache_pkg::cache_req_t  req;
  logic                   resp_valid;
  cache_pkg::cache_resp_t resp;
  logic                   req_credit;

  // Reference model state
  cache_pkg::word_t ref_mem [int];
  int               lru_lines [NUM_SETS][$];
  logic             credit_held;
  int               issued;
  int               responses;
  int               cycle_count;
  integer           seed;

  cache_top #(
    .NUM_SETS(NUM_SETS),
    .NUM_WAYS(NUM_WAYS),
    .MEM_CREDITS(MEM_CREDITS),
    .MEM_LATENCY(MEM_LATENCY)
  ) dut (
    .clk(clk),
    .reset(reset),
    .req_valid(req_valid),
    .req(req),
    .resp_valid(resp_valid),
    .resp(resp),
    .req_credit(req_credit)
  );

  bind cache_ctrl cache_properties #(
    .MEM_CREDITS(MEM_CREDITS)
  ) ctrl_props (
    .clk(clk),
    .reset(reset),
    .credits(credits),
    .mem_req_valid(mem_req_valid),
    .resp_valid(resp_valid),
    .req_credit(req_credit)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_failed();
    $display("Verification failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected === actual) else begin
      $display("** Error at time %0t: %s expected 0x%08h, actual 0x%08h",
               $time, name, expected, actual);
      stop_failed();
    end
  endtask

  function automatic logic [31:0] line_address(input int set, input int k, input int word);
    return 32'(((set + NUM_SETS * k) << cache_pkg::OFFSET_W) + 4 * word);
  endfunction

  // Flat memory view plus a most-recent-first list of lines per set
  function automatic void predict(input logic write, input logic [31:0] addr,
                                  input cache_pkg::word_t wdata, output logic hit,
                                  output cache_pkg::word_t rdata);
    int line_no;
    int set;
    int pos;
    int waddr;
    line_no = int'(addr >> cache_pkg::OFFSET_W);
    set = line_no % NUM_SETS;
    waddr = int'(addr >> 2);
    pos = -1;
    for (int i = 0; i < lru_lines[set].size(); i++) begin
      if (lru_lines[set][i] == line_no) begin
        pos = i;
      end
    end
    hit = (pos >= 0);
    if (hit) begin
      lru_lines[set].delete(pos);
    end else if (lru_lines[set].size() == NUM_WAYS) begin
      void'(lru_lines[set].pop_back());
    end
    lru_lines[set].push_front(line_no);
    if (write) begin
      ref_mem[waddr] = wdata;
      rdata = wdata;
    end else begin
      rdata = ref_mem.exists(waddr) ? ref_mem[waddr] : {addr[31:2], 2'b00};
    end
  endfunction

  // Called right after a rising edge, returns right after one
  task automatic access_cache(input logic write, input logic [31:0] addr,
                              input cache_pkg::word_t wdata);
    logic             exp_hit;
    cache_pkg::word_t exp_rdata;
    int               latency;
    predict(write, addr, wdata, exp_hit, exp_rdata);
    assert (credit_held) else begin
      $display("Client tried to send a request without holding its credit");
      stop_failed();
    end
    credit_held = 1'b0;
    req_valid <= 1'b1;
    req <= cache_pkg::cache_req_t'{write: write, addr: addr, wdata: wdata};
    issued++;
    @(posedge clk);
    req_valid <= 1'b0;
    latency = 0;
    do begin
      @(negedge clk);
      latency++;
    end while (!resp_valid);
    check_value("req_credit", 32'd1, {31'd0, req_credit});
    check_value("resp.hit", {31'd0, exp_hit}, {31'd0, resp.hit});
    check_value("resp.rdata", exp_rdata, resp.rdata);
    if (exp_hit) begin
      check_value("hit latency", 32'd1, latency);
    end else begin
      assert (latency >= MEM_LATENCY + 3) else begin
        $display("** Error at time %0t: miss latency expected at least %0d, actual %0d",
                 $time, MEM_LATENCY + 3, latency);
        stop_failed();
      end
    end
    @(posedge clk);
    check_value("response count", issued, responses);
  endtask

  // The client credit comes back only through req_credit
  always @(negedge clk) begin
    if (resp_valid) begin
      responses++;
    end
    if (req_credit) begin
      assert (!credit_held) else begin
        $display("The cache returned a request credit that the client already held");
        stop_failed();
      end
      credit_held = 1'b1;
    end
  end

  // Watchdog and bound protocol checks
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: a cache response never arrived within %0d cycles", cycle_count);
      stop_failed();
    end
    if (dut.u_ctrl.ctrl_props.failures != 0) begin
      $display("A protocol assertion on the cache controller failed");
      stop_failed();
    end
  end

  initial begin
    integer r;
    seed = 77;
    issued = 0;
    responses = 0;
    cycle_count = 0;
    credit_held = 1'b0;
    reset = 1'b1;
    req_valid = 1'b0;
    req = '0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    credit_held = 1'b1;

    // Cold miss, then hits on the same line
    access_cache(1'b0, line_address(3, 0, 1), '0);
    access_cache(1'b0, line_address(3, 0, 1), '0);
    access_cache(1'b0, line_address(3, 0, 2), '0);
    // Write hit and write miss, each read back
    access_cache(1'b1, line_address(3, 0, 1), 32'hcafe_0001);
    access_cache(1'b0, line_address(3, 0, 1), '0);
    access_cache(1'b1, line_address(5, 0, 3), 32'h5a5a_0003);
    access_cache(1'b0, line_address(5, 0, 3), '0);
    // Two more lines in set 5 push the dirty one out
    access_cache(1'b0, line_address(5, 1, 0), '0);
    access_cache(1'b0, line_address(5, 2, 0), '0);
    access_cache(1'b0, line_address(5, 0, 3), '0);
    // A, B, A, C in set 6 evicts B
    access_cache(1'b0, line_address(6, 0, 0), '0);
    access_cache(1'b0, line_address(6, 1, 0), '0);
    access_cache(1'b0, line_address(6, 0, 1), '0);
    access_cache(1'b0, line_address(6, 2, 0), '0);
    access_cache(1'b0, line_address(6, 0, 2), '0);
    access_cache(1'b0, line_address(6, 1, 1), '0);

    // Mixed traffic over three lines in each of sets 1 and 2
    for (int i = 0; i < NUM_RANDOM; i++) begin
      r = $random(seed);
      access_cache(r[8], line_address(r[0] ? 2 : 1, int'(r[5:4]) % 3, int'(r[3:2])),
                   $random(seed));
    end

    repeat (4) @(posedge clk);
    check_value("response count", issued, responses);
    if (dut.u_ctrl.ctrl_props.failures == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("Protocol assertions failed %0d times", dut.u_ctrl.ctrl_props.failures);
      stop_failed();
    end
  end

endmodule

`default_nettype wire

// ==== verification/cache_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_properties #(
  parameter int MEM_CREDITS = 2,
  localparam int CRED_W = $clog2(MEM_CREDITS + 1)
) (
  input logic              clk,
  input logic              reset,
  input logic [CRED_W-1:0] credits,
  input logic              mem_req_valid,
  input logic              resp_valid,
  input logic              req_credit
);

  int failures;

  initial failures = 0;

  // Credits come back only for requests that were sent
  credit_bound: assert property (@(posedge clk) disable iff (reset)
    credits <= CRED_W'(MEM_CREDITS))
    else begin
      failures++;
      $error("memory credit count %0d exceeds %0d", credits, MEM_CREDITS);
    end

  send_needs_credit: assert property (@(posedge clk) disable iff (reset)
    mem_req_valid |-> credits != '0)
    else begin
      failures++;
      $error("memory request sent with no credit left");
    end

  // The client credit returns with every response
  credit_with_resp: assert property (@(posedge clk) disable iff (reset)
    resp_valid == req_credit)
    else begin
      failures++;
      $error("resp_valid %0b and req_credit %0b differ", resp_valid, req_credit);
    end

endmodule

`default_nettype wire

// ==== verilog/cache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_top #(
  parameter int NUM_SETS = 8,
  parameter int NUM_WAYS = 2,
  parameter int MEM_CREDITS = 2,
  parameter int MEM_LATENCY = 6,
  localparam int IDX_W = $clog2(NUM_SETS),
  localparam int TAG_W = cache_pkg::LINE_ADDR_W - IDX_W,
  localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req_valid,
  input  cache_pkg::cache_req_t  req,
  output logic                   resp_valid,
  output cache_pkg::cache_resp_t resp,
  output logic                   req_credit
);

  // Controller to ways
  logic [IDX_W-1:0]                 index;
  logic [TAG_W-1:0]                 tag;
  cache_pkg::way_op_e               op;
  logic [NUM_WAYS-1:0]              way_sel;
  logic [cache_pkg::WORD_SEL_W-1:0] word_offset;
  cache_pkg::word_t                 wdata;
  cache_pkg::line_t                 fill_line;

  // Ways to merge block
  logic [NUM_WAYS-1:0]              way_hit;
  cache_pkg::line_t                 way_line [NUM_WAYS];
  logic [TAG_W-1:0]                 way_tag [NUM_WAYS];
  logic [NUM_WAYS-1:0]              way_dirty;

  // Merge block to controller
  logic [WAY_W-1:0]                 victim;
  logic [NUM_WAYS-1:0]              hit_vec;
  logic                             any_hit;
  cache_pkg::word_t                 rdata;
  cache_pkg::line_t                 victim_line;
  logic [TAG_W-1:0]                 victim_tag;
  logic                             victim_dirty;

  // Memory
  logic                             mem_req_valid;
  cache_pkg::mem_req_t              mem_req;
  logic                             mem_credit;
  logic                             mem_resp_valid;
  cache_pkg::mem_resp_t             mem_resp;

  cache_ctrl #(
    .NUM_SETS(NUM_SETS),
    .NUM_WAYS(NUM_WAYS),
    .MEM_CREDITS(MEM_CREDITS)
  ) u_ctrl (
    .clk(clk),
    .reset(reset),
    .req_valid(req_valid),
    .req(req),
    .resp_valid(resp_valid),
    .resp(resp),
    .req_credit(req_credit),
    .index(index),
    .tag(tag),
    .op(op),
    .way_sel(way_sel),
    .word_offset(word_offset),
    .wdata(wdata),
    .fill_line(fill_line),
    .victim(victim),
    .hit_vec(hit_vec),
    .any_hit(any_hit),
    .rdata(rdata),
    .victim_line(victim_line),
    .victim_tag(victim_tag),
    .victim_dirty(victim_dirty),
    .mem_req_valid(mem_req_valid),
    .mem_req(mem_req),
    .mem_credit(mem_credit),
    .mem_resp_valid(mem_resp_valid),
    .mem_resp(mem_resp)
  );

  for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
    cache_way #(
      .NUM_SETS(NUM_SETS)
    ) u_way (
      .clk(clk),
      .reset(reset),
      .index(index),
      .tag(tag),
      .op(op),
      .sel(way_sel[g]),
      .word_offset(word_offset),
      .wdata(wdata),
      .fill_line(fill_line),
      .hit(way_hit[g]),
      .line(way_line[g]),
      .stored_tag(way_tag[g]),
      .dirty(way_dirty[g])
    );
  end

  hit_merge #(
    .NUM_SETS(NUM_SETS),
    .NUM_WAYS(NUM_WAYS)
  ) u_merge (
    .way_hit(way_hit),
    .way_line(way_line),
    .way_tag(way_tag),
    .way_dirty(way_dirty),
    .word_offset(word_offset),
    .victim(victim),
    .hit_vec(hit_vec),
    .any_hit(any_hit),
    .rdata(rdata),
    .victim_line(victim_line),
    .victim_tag(victim_tag),
    .victim_dirty(victim_dirty)
  );

  line_memory #(
    .MEM_CREDITS(MEM_CREDITS),
    .MEM_LATENCY(MEM_LATENCY)
  ) u_mem (
    .clk(clk),
    .reset(reset),
    .req_valid(mem_req_valid),
    .req(mem_req),
    .credit(mem_credit),
    .resp_valid(mem_resp_valid),
    .resp(mem_resp)
  );

endmodule

`default_nettype wire

// ==== verilog/line_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

module line_memory #(
  parameter int MEM_CREDITS = 2,
  parameter int MEM_LATENCY = 6,
  localparam int DEPTH = 64,
  localparam int MEM_IDX_W = $clog2(DEPTH),
  localparam int PTR_W = (MEM_CREDITS > 1) ? $clog2(MEM_CREDITS) : 1,
  localparam int CNT_W = $clog2(MEM_CREDITS + 1)
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req_valid,
  input  cache_pkg::mem_req_t  req,
  output logic                 credit,
  output logic                 resp_valid,
  output cache_pkg::mem_resp_t resp
);

  cache_pkg::line_t       mem [DEPTH];
  cache_pkg::mem_req_t    queue [MEM_CREDITS];
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic [CNT_W-1:0]       count;
  cache_pkg::mem_req_t    head;
  logic                   pop;
  logic [MEM_IDX_W-1:0]   head_idx;
  logic [MEM_LATENCY-1:0] pipe_valid;
  cache_pkg::line_t       pipe_line [MEM_LATENCY];

  // One request leaves the queue per cycle and returns its credit
  assign head = queue[rd_ptr];
  assign pop = (count != '0);
  assign credit = pop;
  assign head_idx = head.line_addr[MEM_IDX_W-1:0];

  always_ff @(posedge clk) begin
    if (req_valid) begin
      queue[wr_ptr] <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (req_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(MEM_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(MEM_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(req_valid) - CNT_W'(pop);
    end
  end

  // After reset every word holds its own byte address
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
          mem[i][w] <= cache_pkg::word_t'((i << cache_pkg::OFFSET_W) + 4 * w);
        end
      end
    end else if (pop && head.write) begin
      mem[head_idx] <= head.line;
    end
  end

  // Read data comes out MEM_LATENCY cycles after the pop
  always_ff @(posedge clk) begin
    if (reset) begin
      pipe_valid <= '0;
    end else begin
      pipe_valid[0] <= pop && !head.write;
      for (int s = 1; s < MEM_LATENCY; s++) begin
        pipe_valid[s] <= pipe_valid[s-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    pipe_line[0] <= mem[head_idx];
    for (int s = 1; s < MEM_LATENCY; s++) begin
      pipe_line[s] <= pipe_line[s-1];
    end
  end

  assign resp_valid = pipe_valid[MEM_LATENCY-1];
  assign resp.line = pipe_line[MEM_LATENCY-1];

endmodule

`default_nettype wire

// ==== verilog/cache_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl #(
  parameter int NUM_SETS = 8,
  parameter int NUM_WAYS = 2,
  parameter int MEM_CREDITS = 2,
  localparam int IDX_W = $clog2(NUM_SETS),
  localparam int TAG_W = cache_pkg::LINE_ADDR_W - IDX_W,
  localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1,
  localparam int CRED_W = $clog2(MEM_CREDITS + 1)
) (
  input  logic                             clk,
  input  logic                             reset,
  // Client
  input  logic                             req_valid,
  input  cache_pkg::cache_req_t            req,
  output logic                             resp_valid,
  output cache_pkg::cache_resp_t           resp,
  output logic                             req_credit,
  // To the ways
  output logic [IDX_W-1:0]                 index,
  output logic [TAG_W-1:0]                 tag,
  output cache_pkg::way_op_e               op,
  output logic [NUM_WAYS-1:0]              way_sel,
  output logic [cache_pkg::WORD_SEL_W-1:0] word_offset,
  output cache_pkg::word_t                 wdata,
  output cache_pkg::line_t                 fill_line,
  // From the merge block
  output logic [WAY_W-1:0]                 victim,
  input  logic [NUM_WAYS-1:0]              hit_vec,
  input  logic                             any_hit,
  input  cache_pkg::word_t                 rdata,
  input  cache_pkg::line_t                 victim_line,
  input  logic [TAG_W-1:0]                 victim_tag,
  input  logic                             victim_dirty,
  // Memory
  output logic                             mem_req_valid,
  output cache_pkg::mem_req_t              mem_req,
  input  logic                             mem_credit,
  input  logic                             mem_resp_valid,
  input  cache_pkg::mem_resp_t             mem_resp
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOOKUP,
    S_WB,
    S_FILL,
    S_WAIT,
    S_MARK
  } state_e;

  state_e                state;
  state_e                next_state;
  cache_pkg::cache_req_t req_q;
  logic [CRED_W-1:0]     credits;
  logic [WAY_W-1:0]      age [NUM_SETS][NUM_WAYS];
  logic                  touch;
  logic [WAY_W-1:0]      touch_way;
  logic [WAY_W-1:0]      hit_way;

  // Every way sees the same registered request
  assign index = req_q.addr[cache_pkg::OFFSET_W +: IDX_W];
  assign tag = req_q.addr[cache_pkg::ADDR_W-1 -: TAG_W];
  assign word_offset = req_q.addr[cache_pkg::OFFSET_W-1 -: cache_pkg::WORD_SEL_W];
  assign wdata = req_q.wdata;
  assign fill_line = mem_resp.line;
  assign req_credit = resp_valid;

  always_ff @(posedge clk) begin
    if (state == S_IDLE && req_valid) begin
      req_q <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_IDLE;
    end else begin
      state <= next_state;
    end
  end

  // One credit per queue slot in the line memory
  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= CRED_W'(MEM_CREDITS);
    end else begin
      credits <= credits + CRED_W'(mem_credit) - CRED_W'(mem_req_valid);
    end
  end

  // LRU as per-set age ranks; the oldest way has rank NUM_WAYS-1
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
          age[s][w] <= WAY_W'(w);
        end
      end
    end else if (touch) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (WAY_W'(w) == touch_way) begin
          age[index][w] <= '0;
        end else if (age[index][w] < age[index][touch_way]) begin
          age[index][w] <= age[index][w] + 1'b1;
        end
      end
    end
  end

  always_comb begin
    victim = '0;
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (age[index][w] == WAY_W'(NUM_WAYS - 1)) begin
        victim = WAY_W'(w);
      end
      if (hit_vec[w]) begin
        hit_way = WAY_W'(w);
      end
    end
  end

  always_comb begin
    next_state = state;
    op = cache_pkg::WAY_IDLE;
    way_sel = '0;
    resp_valid = 1'b0;
    resp = '0;
    mem_req_valid = 1'b0;
    mem_req = '0;
    touch = 1'b0;
    touch_way = victim;
    case (state)
      S_IDLE: begin
        if (req_valid) begin
          next_state = S_LOOKUP;
        end
      end
      S_LOOKUP: begin
        if (any_hit) begin
          resp_valid = 1'b1;
          resp.hit = 1'b1;
          resp.rdata = req_q.write ? req_q.wdata : rdata;
          touch = 1'b1;
          touch_way = hit_way;
          if (req_q.write) begin
            op = cache_pkg::WAY_WRITE_WORD;
            way_sel = hit_vec;
          end
          next_state = S_IDLE;
        end else begin
          next_state = victim_dirty ? S_WB : S_FILL;
        end
      end
      S_WB: begin
        // Victim goes out first, fill follows without waiting for it
        if (credits != '0) begin
          mem_req_valid = 1'b1;
          mem_req.write = 1'b1;
          mem_req.line_addr = {victim_tag, index};
          mem_req.line = victim_line;
          op = cache_pkg::WAY_CLEAN;
          way_sel = NUM_WAYS'(1) << victim;
          next_state = S_FILL;
        end
      end
      S_FILL: begin
        if (credits != '0) begin
          mem_req_valid = 1'b1;
          mem_req.line_addr = req_q.addr[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W];
          next_state = S_WAIT;
        end
      end
      S_WAIT: begin
        if (mem_resp_valid) begin
          op = cache_pkg::WAY_FILL;
          way_sel = NUM_WAYS'(1) << victim;
          touch = 1'b1;
          if (req_q.write) begin
            next_state = S_MARK;
          end else begin
            resp_valid = 1'b1;
            resp.rdata = mem_resp.line[word_offset];
            next_state = S_IDLE;
          end
        end
      end
      S_MARK: begin
        // The filled way hits now; merge the write word and set dirty
        op = cache_pkg::WAY_WRITE_WORD;
        way_sel = hit_vec;
        resp_valid = 1'b1;
        resp.rdata = req_q.wdata;
        next_state = S_IDLE;
      end
      default: next_state = S_IDLE;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/hit_merge.sv ====
`timescale 1ns/10ps
`default_nettype none

module hit_merge #(
  parameter int NUM_SETS = 8,
  parameter int NUM_WAYS = 2,
  localparam int TAG_W = cache_pkg::LINE_ADDR_W - $clog2(NUM_SETS),
  localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1
) (
  input  logic [NUM_WAYS-1:0]              way_hit,
  input  cache_pkg::line_t                 way_line [NUM_WAYS],
  input  logic [TAG_W-1:0]                 way_tag [NUM_WAYS],
  input  logic [NUM_WAYS-1:0]              way_dirty,
  input  logic [cache_pkg::WORD_SEL_W-1:0] word_offset,
  input  logic [WAY_W-1:0]                 victim,
  output logic [NUM_WAYS-1:0]              hit_vec,
  output logic                             any_hit,
  output cache_pkg::word_t                 rdata,
  output cache_pkg::line_t                 victim_line,
  output logic [TAG_W-1:0]                 victim_tag,
  output logic                             victim_dirty
);

  assign hit_vec = way_hit;
  assign any_hit = |way_hit;

  // At most one way hits, so an OR of the masked words is enough
  always_comb begin
    rdata = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (way_hit[w]) begin
        rdata = rdata | way_line[w][word_offset];
      end
    end
  end

  // Victim state for a possible write-back
  assign victim_line = way_line[victim];
  assign victim_tag = way_tag[victim];
  assign victim_dirty = way_dirty[victim];

endmodule

`default_nettype wire

// ==== verilog/cache_way.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_way #(
  parameter int NUM_SETS = 8,
  localparam int IDX_W = $clog2(NUM_SETS),
  localparam int TAG_W = cache_pkg::LINE_ADDR_W - IDX_W
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [IDX_W-1:0]                 index,
  input  logic [TAG_W-1:0]                 tag,
  input  cache_pkg::way_op_e               op,
  input  logic                             sel,
  input  logic [cache_pkg::WORD_SEL_W-1:0] word_offset,
  input  cache_pkg::word_t                 wdata,
  input  cache_pkg::line_t                 fill_line,
  output logic                             hit,
  output cache_pkg::line_t                 line,
  output logic [TAG_W-1:0]                 stored_tag,
  output logic                             dirty
);

  logic [TAG_W-1:0]    tags [NUM_SETS];
  cache_pkg::line_t    lines [NUM_SETS];
  logic [NUM_SETS-1:0] valid;
  logic [NUM_SETS-1:0] dirty_bits;

  // Lookup is combinational on the controller's registered index
  assign hit = valid[index] && (tags[index] == tag);
  assign line = lines[index];
  assign stored_tag = tags[index];
  assign dirty = dirty_bits[index];

  // Status bits
  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
      dirty_bits <= '0;
    end else if (sel) begin
      case (op)
        cache_pkg::WAY_FILL: begin
          valid[index] <= 1'b1;
          dirty_bits[index] <= 1'b0;
        end
        cache_pkg::WAY_WRITE_WORD: dirty_bits[index] <= 1'b1;
        cache_pkg::WAY_CLEAN: dirty_bits[index] <= 1'b0;
        default: ;
      endcase
    end
  end

  // Tag and data arrays
  always_ff @(posedge clk) begin
    if (sel && op == cache_pkg::WAY_FILL) begin
      tags[index] <= tag;
      lines[index] <= fill_line;
    end else if (sel && op == cache_pkg::WAY_WRITE_WORD) begin
      lines[index][word_offset] <= wdata;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

  // Address layout
  localparam int ADDR_W = 32;
  localparam int OFFSET_W = 4;
  localparam int LINE_ADDR_W = ADDR_W - OFFSET_W;

  // Address bits [3:2] pick one of four words in a line
  localparam int WORDS_PER_LINE = 4;
  localparam int WORD_SEL_W = 2;

  typedef logic [31:0] word_t;
  typedef word_t [WORDS_PER_LINE-1:0] line_t;

  // Client side
  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    word_t             wdata;
  } cache_req_t;

  typedef struct packed {
    logic  hit;
    word_t rdata;
  } cache_resp_t;

  // Memory side carries whole lines
  typedef struct packed {
    logic                   write;
    logic [LINE_ADDR_W-1:0] line_addr;
    line_t                  line;
  } mem_req_t;

  typedef struct packed {
    line_t line;
  } mem_resp_t;

  // Commands from the controller to a selected way
  typedef enum logic [1:0] {
    WAY_IDLE,
    WAY_FILL,        // whole line, tag and valid, leaves it clean
    WAY_WRITE_WORD,  // one word, marks the line dirty
    WAY_CLEAN
  } way_op_e;

endpackage

`default_nettype wire
